// ==== sim.f ====
verilog/io_pkg.sv
verilog/io_decode.sv
verilog/gpio_port.sv
verilog/pwm_led.sv
verilog/uart_tx.sv
verilog/io_read_mux.sv
verilog/port_controller.sv
verification/port_controller_tb.sv

// ==== verification/port_controller_tb.sv ====
// ==========================================================
// Testbench for the IO port controller. Drives the cpu bus
// with directed and random accesses, keeps shadow registers
// and checks read data, pins, PWM duty and UART frames.
// ==========================================================
`timescale 1ns/1ps

module port_controller_tb;
	import io_pkg::*;

	localparam int CLOCK_FREQ     = 1600000;
	localparam int BAUD_RATE      = 100000;
	localparam int BIT_CYC        = CLOCK_FREQ / BAUD_RATE;	// 16 cycles per bit
	localparam int TIMEOUT_CYCLES = 12000;	// tests need about 3500

	localparam logic [15:0] A_UART     = {BASE_UART, 4'd0};
	localparam logic [15:0] A_GPIO_OUT = {BASE_GPIO, OFF_GPIO_OUT};
	localparam logic [15:0] A_GPIO_IN  = {BASE_GPIO, OFF_GPIO_IN};

	logic              CLK;
	logic              RSTb;
	io_req_t           bus;
	logic [DATA_W-1:0] rdata;
	logic [5:0]        gpio_in;
	logic [3:0]        gpio_out;
	logic [2:0]        led;
	logic              uart_txd;

	// shadow registers
	logic [3:0]        sh_gpio_out;
	logic [7:0]        sh_duty [3];
	logic              sh_busy;
	logic [5:0]        pin_val;	// settled pin value
	logic [DATA_W-1:0] exp_q [$];	// expected read data, in order
	int                cycles;

	port_controller #(
		.CLOCK_FREQ (CLOCK_FREQ),
		.BAUD_RATE  (BAUD_RATE),
		.PWM_BITS   (8)
	) UUT (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.bus      (bus),
		.rdata    (rdata),
		.gpio_in  (gpio_in),
		.gpio_out (gpio_out),
		.led      (led),
		.uart_txd (uart_txd)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("FAIL at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// expected read word from the register map
	function automatic logic [DATA_W-1:0] ref_read(input logic [15:0] addr);
		logic [DATA_W-1:0] r;
		r = '0;
		case (addr[15:4])
			BASE_UART: if (addr[3:0] == 4'd0) r = DATA_W'(sh_busy);
			BASE_GPIO: begin
				if (addr[3:0] == OFF_GPIO_OUT) r = DATA_W'(sh_gpio_out);
				else if (addr[3:0] == OFF_GPIO_IN) r = DATA_W'(pin_val);
			end
			BASE_PWM:  if (addr[3:0] < 4'd3) r = DATA_W'(sh_duty[addr[1:0]]);
			default: ;
		endcase
		return r;
	endfunction

	task automatic model_write(input logic [15:0] addr, input logic [DATA_W-1:0] data);
		case (addr[15:4])
			BASE_UART: if (addr[3:0] == 4'd0) sh_busy = 1'b1;	// dropped if already busy
			BASE_GPIO: if (addr[3:0] == OFF_GPIO_OUT) sh_gpio_out = data[3:0];
			BASE_PWM:  if (addr[3:0] < 4'd3) sh_duty[addr[1:0]] = data[7:0];
			default: ;
		endcase
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [DATA_W-1:0] data);
		@(posedge CLK);
		bus <= {addr, data, 1'b1, 1'b0};
		@(posedge CLK);
		bus <= '0;
		model_write(addr, data);
		@(negedge CLK);	// register has taken the write
	endtask

	task automatic bus_read(input logic [15:0] addr);
		@(posedge CLK);
		bus <= {addr, 16'h0000, 1'b0, 1'b1};
		@(posedge CLK);	// address captured here
		bus <= '0;
		exp_q.push_back(ref_read(addr));
		@(negedge CLK);
	endtask

	task automatic read_all();
		bus_read(A_UART);
		bus_read(A_GPIO_OUT);
		bus_read(A_GPIO_IN);
		for (int i = 0; i < 3; i++) bus_read({BASE_PWM, 4'(i)});
	endtask

	// compares each read one cycle after capture
	always @(negedge CLK) begin
		if (exp_q.size() > 0) check(rdata, exp_q.pop_front(), "read data");
	end

	initial begin
		logic [15:0] addr;
		logic [15:0] data;
		logic [7:0]  tx_byte;
		int          k;
		int          cnt [3];
		void'($urandom(32'he0db_c340));
		RSTb    <= 1'b0;
		bus     <= '0;
		gpio_in <= 6'h2a;
		pin_val = 6'h2a;
		sh_gpio_out = 4'h0;
		sh_duty = '{8'h00, 8'h00, 8'h00};
		sh_busy = 1'b0;
		repeat (16) @(posedge CLK);
		RSTb <= 1'b1;
		repeat (4) @(posedge CLK);	// let the pin synchronizer fill
		@(negedge CLK);
		check(uart_txd, 1'b1, "txd after reset");
		check(gpio_out, 4'h0, "gpio_out after reset");
		check(led, 3'b000, "led after reset");
		read_all();

		repeat (40) begin	// gpio and pwm readback
			k = $urandom_range(3, 0);
			addr = (k == 3) ? A_GPIO_OUT : {BASE_PWM, 4'(k)};
			data = 16'($urandom());
			bus_write(addr, data);
			check(gpio_out, sh_gpio_out, "gpio_out pins");
			bus_read(addr);
		end

		repeat (30) begin	// unmapped pages
			addr = 16'($urandom());
			while (addr[15:4] inside {BASE_UART, BASE_GPIO, BASE_PWM}) addr = 16'($urandom());
			bus_write(addr, 16'($urandom()));
			bus_read(addr);
		end
		read_all();

		for (int n = 0; n < 5; n++) begin
			for (int i = 0; i < 3; i++) begin
				data = (n == 0) ? 16'(i * 255 / 2) : 16'($urandom_range(255, 0));	// 0 127 255 first
				bus_write({BASE_PWM, 4'(i)}, data);
			end
			repeat (2) @(posedge CLK);
			cnt = '{0, 0, 0};
			repeat (256) begin
				@(negedge CLK);
				for (int i = 0; i < 3; i++) cnt[i] += led[i];
			end
			for (int i = 0; i < 3; i++) check(cnt[i], sh_duty[i], "led high cycles");
		end

		repeat (2) begin
			tx_byte = 8'($urandom());
			bus_write(A_UART, {8'h00, tx_byte});
			fork
				begin
					repeat (BIT_CYC / 2) @(posedge CLK);	// middle of start bit
					@(negedge CLK);
					check(uart_txd, 1'b0, "uart start bit");
					for (int b = 0; b < 9; b++) begin
						repeat (BIT_CYC) @(posedge CLK);
						@(negedge CLK);
						check(uart_txd, (b < 8) ? tx_byte[b] : 1'b1, "uart frame bit");
					end
				end
				begin
					repeat (40) @(posedge CLK);
					bus_read(A_UART);	// busy mid frame
					bus_write(A_UART, 16'h00a5);	// must be dropped
				end
			join
			repeat (BIT_CYC) @(posedge CLK);
			sh_busy = 1'b0;
			bus_read(A_UART);
			repeat (200) begin
				@(negedge CLK);
				check(uart_txd, 1'b1, "uart line idle after frame");
			end
		end

		repeat (6) begin	// gpio input path
			data = 16'($urandom());
			@(posedge CLK);
			gpio_in <= data[5:0];
			repeat (2) @(posedge CLK);
			pin_val = data[5:0];
			bus_read(A_GPIO_IN);
		end

		repeat (2) @(posedge CLK);
		check(exp_q.size(), 0, "reads left unchecked");
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== verilog/port_controller.sv ====
// ==========================================================
// IO port controller top. Decodes the cpu bus onto a UART
// transmitter, a GPIO port and a PWM LED driver, and
// returns registered read data one cycle after a read.
// ==========================================================
`timescale 1ns/1ps

module port_controller #(
	parameter int CLOCK_FREQ = 10000000,
	parameter int BAUD_RATE  = 115200,
	parameter int PWM_BITS   = 8
) (
	input  logic                      CLK,
	input  logic                      RSTb,
	input  io_pkg::io_req_t           bus,
	output logic [io_pkg::DATA_W-1:0] rdata,
	input  logic [5:0]                gpio_in,
	output logic [3:0]                gpio_out,
	output logic [2:0]                led,
	output logic                      uart_txd
);
	import io_pkg::*;

	io_wr_t            wr_bus;
	io_sel_e           sel;
	logic [DATA_W-1:0] uart_word;
	logic [DATA_W-1:0] gpio_word;
	logic [DATA_W-1:0] pwm_word;

	io_decode u_decode (
		.bus    (bus),
		.wr_bus (wr_bus),
		.sel    (sel)
	);

	uart_tx #(
		.CLOCK_FREQ (CLOCK_FREQ),
		.BAUD_RATE  (BAUD_RATE)
	) u_uart (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.wr_bus  (wr_bus),
		.txd     (uart_txd),
		.rd_word (uart_word)
	);

	gpio_port u_gpio (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.wr_bus   (wr_bus),
		.gpio_in  (gpio_in),
		.gpio_out (gpio_out),
		.rd_word  (gpio_word)
	);

	pwm_led #(
		.PWM_BITS (PWM_BITS)
	) u_pwm (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.wr_bus  (wr_bus),
		.led     (led),
		.rd_word (pwm_word)
	);

	io_read_mux u_rmux (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.rd        (bus.rd),
		.sel       (sel),
		.uart_word (uart_word),
		.gpio_word (gpio_word),
		.pwm_word  (pwm_word),
		.rdata     (rdata)
	);

endmodule

// ==== verilog/io_read_mux.sv ====
// ==========================================================
// Read result stage. On a read the word of the selected
// block is registered and held on rdata until the next
// read, so data shows one cycle after the address.
// ==========================================================
`timescale 1ns/1ps

module io_read_mux (
	input  logic                      CLK,
	input  logic                      RSTb,
	input  logic                      rd,
	input  io_pkg::io_sel_e           sel,
	input  logic [io_pkg::DATA_W-1:0] uart_word,
	input  logic [io_pkg::DATA_W-1:0] gpio_word,
	input  logic [io_pkg::DATA_W-1:0] pwm_word,
	output logic [io_pkg::DATA_W-1:0] rdata
);
	import io_pkg::*;

	logic [DATA_W-1:0] rd_next;

	always_comb begin
		case (sel)
			SEL_UART: rd_next = uart_word;
			SEL_GPIO: rd_next = gpio_word;
			SEL_PWM:  rd_next = pwm_word;
			default:  rd_next = '0;	// SEL_NONE
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			rdata <= '0;
		end else if (rd) begin
			rdata <= rd_next;
		end
	end

	a_sel_known: assert property (@(posedge CLK) disable iff (!RSTb)
		rd |-> !$isunknown(sel))
		else $error("io_read_mux: read with unknown select");

endmodule

// ==== verilog/uart_tx.sv ====
// ==========================================================
// 8N1 UART transmitter. A write to offset 0 while idle
// sends wdata[7:0]; writes while busy are dropped. Reading
// offset 0 returns busy in bit 0.
// ==========================================================
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLOCK_FREQ = 10000000,
	parameter int BAUD_RATE  = 115200
) (
	input  logic                      CLK,
	input  logic                      RSTb,
	input  io_pkg::io_wr_t            wr_bus,
	output logic                      txd,
	output logic [io_pkg::DATA_W-1:0] rd_word
);
	import io_pkg::*;

	localparam int DIV   = CLOCK_FREQ / BAUD_RATE;	// cycles per bit
	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

	uart_state_e      state;
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shreg;
	logic             busy;
	logic             bit_end;
	logic             start_req;

	assign busy      = (state != IDLE);
	assign bit_end   = (baud_cnt == CNT_W'(DIV - 1));
	assign start_req = wr_bus.uart && (wr_bus.off == 4'd0) && !busy;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state    <= IDLE;
			txd      <= 1'b1;	// line idles high
			baud_cnt <= '0;
			bit_idx  <= 3'd0;
		end else begin
			baud_cnt <= (bit_end || state == IDLE) ? '0 : baud_cnt + 1'b1;
			case (state)
				IDLE: if (start_req) begin
					state <= START;
					txd   <= 1'b0;
				end
				START: if (bit_end) begin
					state   <= DATA;
					txd     <= shreg[0];	// lsb first
					bit_idx <= 3'd0;
				end
				DATA: if (bit_end) begin
					if (bit_idx == 3'd7) begin
						state <= STOP;
						txd   <= 1'b1;
					end else begin
						bit_idx <= bit_idx + 1'b1;
						txd     <= shreg[0];
					end
				end
				STOP: if (bit_end) begin
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// byte is latched on accept, then shifted as each bit goes out
	always_ff @(posedge CLK) begin
		if (start_req) begin
			shreg <= wr_bus.data[7:0];
		end else if (bit_end && (state == START || state == DATA)) begin
			shreg <= {1'b0, shreg[7:1]};
		end
	end

	assign rd_word = (wr_bus.off == 4'd0) ? DATA_W'(busy) : '0;

	a_idle_high: assert property (@(posedge CLK) disable iff (!RSTb)
		(state == IDLE) |-> txd)
		else $error("uart_tx: txd low while idle");

endmodule

// ==== verilog/pwm_led.sv ====
// ==========================================================
// Three channel PWM LED driver. Each channel has a duty
// register at offsets 0..2; a shared free running counter
// sets the period to 2^PWM_BITS cycles.
// ==========================================================
`timescale 1ns/1ps

module pwm_led #(
	parameter int PWM_BITS = 8
) (
	input  logic                      CLK,
	input  logic                      RSTb,
	input  io_pkg::io_wr_t            wr_bus,
	output logic [2:0]                led,
	output logic [io_pkg::DATA_W-1:0] rd_word
);
	import io_pkg::*;

	logic [PWM_BITS-1:0] duty [3];
	logic [PWM_BITS-1:0] cnt;	// wraps, no terminal count

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			duty[0] <= '0;
			duty[1] <= '0;
			duty[2] <= '0;
		end else if (wr_bus.pwm) begin
			case (wr_bus.off)
				OFF_PWM0: duty[0] <= wr_bus.data[PWM_BITS-1:0];
				OFF_PWM1: duty[1] <= wr_bus.data[PWM_BITS-1:0];
				OFF_PWM2: duty[2] <= wr_bus.data[PWM_BITS-1:0];
				default: ;	// no register there
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			cnt <= '0;
			led <= 3'b000;
		end else begin
			cnt <= cnt + 1'b1;
			for (int i = 0; i < 3; i++) begin
				led[i] <= (cnt < duty[i]);	// duty 0 keeps the led dark
			end
		end
	end

	always_comb begin
		case (wr_bus.off)
			OFF_PWM0: rd_word = DATA_W'(duty[0]);
			OFF_PWM1: rd_word = DATA_W'(duty[1]);
			OFF_PWM2: rd_word = DATA_W'(duty[2]);
			default:  rd_word = '0;
		endcase
	end

endmodule

// ==== verilog/gpio_port.sv ====
// ==========================================================
// Four bit GPIO output port and six synchronized inputs.
// Offset 0 is the output register, offset 1 reads the pins
// after two flops. Read word is combinational on the offset.
// ==========================================================
`timescale 1ns/1ps

module gpio_port (
	input  logic                      CLK,
	input  logic                      RSTb,
	input  io_pkg::io_wr_t            wr_bus,
	input  logic [5:0]                gpio_in,
	output logic [3:0]                gpio_out,
	output logic [io_pkg::DATA_W-1:0] rd_word
);
	import io_pkg::*;

	logic [5:0] in_meta;	// first stage, may be metastable
	logic [5:0] in_sync;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			gpio_out <= 4'b0000;
		end else if (wr_bus.gpio && wr_bus.off == OFF_GPIO_OUT) begin
			gpio_out <= wr_bus.data[3:0];
		end
	end

	// pins are asynchronous to CLK
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			in_meta <= 6'b0;
			in_sync <= 6'b0;
		end else begin
			in_meta <= gpio_in;
			in_sync <= in_meta;
		end
	end

	always_comb begin
		case (wr_bus.off)
			OFF_GPIO_OUT: rd_word = DATA_W'(gpio_out);
			OFF_GPIO_IN:  rd_word = DATA_W'(in_sync);
			default:      rd_word = '0;
		endcase
	end

endmodule

// ==== verilog/io_decode.sv ====
// ==========================================================
// Address decoder for the IO bus. Purely combinational:
// picks the peripheral from addr[15:4], steers the write
// strobe to it and passes the read select on.
// ==========================================================
`timescale 1ns/1ps

module io_decode (
	input  io_pkg::io_req_t bus,
	output io_pkg::io_wr_t  wr_bus,
	output io_pkg::io_sel_e sel
);
	import io_pkg::*;

	logic [11:0] page;

	assign page = bus.addr[15:4];

	always_comb begin
		case (page)
			BASE_UART: sel = SEL_UART;
			BASE_GPIO: sel = SEL_GPIO;
			BASE_PWM:  sel = SEL_PWM;
			default:   sel = SEL_NONE;	// unmapped, reads zero
		endcase
	end

	always_comb begin
		wr_bus.uart = bus.wr && (sel == SEL_UART);
		wr_bus.gpio = bus.wr && (sel == SEL_GPIO);
		wr_bus.pwm  = bus.wr && (sel == SEL_PWM);
		wr_bus.off  = bus.addr[3:0];
		wr_bus.data = bus.wdata;
	end

endmodule

// ==== verilog/io_pkg.sv ====
// ==========================================================
// Shared types and register map for the IO port controller.
// Compile first; modules import it inside their bodies and
// use scoped names in their port lists.
// ==========================================================
package io_pkg;

	localparam int DATA_W = 16;	// cpu bus word

	// one cpu bus cycle, no wait states
	typedef struct packed {
		logic [15:0]       addr;
		logic [DATA_W-1:0] wdata;
		logic              wr;
		logic              rd;
	} io_req_t;

	// peripheral picked by the upper address bits
	typedef enum logic [1:0] {
		SEL_NONE = 2'd0,
		SEL_UART = 2'd1,
		SEL_GPIO = 2'd2,
		SEL_PWM  = 2'd3
	} io_sel_e;

	// decoded write strobes, at most one high per cycle
	typedef struct packed {
		logic              uart;
		logic              gpio;
		logic              pwm;
		logic [3:0]        off;	// register offset within the block
		logic [DATA_W-1:0] data;
	} io_wr_t;

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		START = 2'd1,
		DATA  = 2'd2,
		STOP  = 2'd3
	} uart_state_e;

	// addr[15:4] of each block
	localparam logic [11:0] BASE_UART = 12'h010;
	localparam logic [11:0] BASE_GPIO = 12'h011;
	localparam logic [11:0] BASE_PWM  = 12'h012;

	localparam logic [3:0] OFF_GPIO_OUT = 4'd0;
	localparam logic [3:0] OFF_GPIO_IN  = 4'd1;	// read only

	localparam logic [3:0] OFF_PWM0 = 4'd0;
	localparam logic [3:0] OFF_PWM1 = 4'd1;
	localparam logic [3:0] OFF_PWM2 = 4'd2;

endpackage
